// ==== hdl/dcache_pkg.sv ====
/* dcache shared definitions
   word, address and strobe widths used across the cache and its testbench */

package dcache_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // processor word
   localparam int WORD_BITS = 32;

   // byte address
   localparam int ADDR_BITS = 32;

   // one strobe bit per byte lane
   localparam int STRB_BITS = WORD_BITS / 8;

   // low address bits that pick a byte inside a word
   localparam int BYTE_OFF_BITS = $clog2(STRB_BITS);

   //////////////////////////////
   // vector types
   //////////////////////////////

   // data word on the load/store port
   typedef logic [WORD_BITS-1:0] word_t;

   // byte address, split as tag | index | word offset | byte offset
   typedef logic [ADDR_BITS-1:0] addr_t;

   // byte write strobe, all zero means a read
   typedef logic [STRB_BITS-1:0] strb_t;

   // lines are built by the modules from LINE_WORDS words,
   // word 0 in the lowest bits

endpackage

// ==== hdl/dcache_ifs.sv ====
/* dcache array ports
   controller-to-array links for line data and for tag/valid/dirty state */
`timescale 1ns/1ps

// line data array port
interface data_port_if #(
   parameter int LINE_WORDS = 4,
   parameter int INDEX_BITS = 4
);
   localparam int LINE_BITS  = LINE_WORDS * dcache_pkg::WORD_BITS;
   localparam int LINE_BYTES = LINE_WORDS * dcache_pkg::STRB_BITS;

   logic [INDEX_BITS-1:0] index;
   logic                  rd_en;
   logic                  wr_en;
   // one enable per byte of the line
   logic [LINE_BYTES-1:0] byte_en;
   logic [LINE_BITS-1:0]  wdata;
   // registered, valid the cycle after rd_en
   logic [LINE_BITS-1:0]  rdata;

   modport ctrl  (output index, rd_en, wr_en, byte_en, wdata, input rdata);
   modport array (input index, rd_en, wr_en, byte_en, wdata, output rdata);
endinterface

// tag array port
interface tag_port_if #(
   parameter int INDEX_BITS = 4,
   parameter int TAG_BITS   = 26
);
   logic [INDEX_BITS-1:0] index;
   logic                  rd_en;
   // write sets valid, dirty follows set_dirty
   logic                  wr_en;
   logic [TAG_BITS-1:0]   wtag;
   logic                  set_dirty;
   // registered read results
   logic [TAG_BITS-1:0]   rtag;
   logic                  rvalid;
   logic                  rdirty;

   modport ctrl  (output index, rd_en, wr_en, wtag, set_dirty,
                  input  rtag, rvalid, rdirty);
   modport array (input  index, rd_en, wr_en, wtag, set_dirty,
                  output rtag, rvalid, rdirty);
endinterface

// ==== hdl/dcache_data_array.sv ====
/* dcache line data array
   one line per index, byte-masked write and registered whole-line read */
`timescale 1ns/1ps

module dcache_data_array #(
   parameter int LINE_WORDS = 4,
   parameter int INDEX_BITS = 4
) (
   input logic      clk,
   data_port_if.array port
);

   localparam int NUM_LINES  = 2 ** INDEX_BITS;
   localparam int LINE_BITS  = LINE_WORDS * dcache_pkg::WORD_BITS;
   localparam int LINE_BYTES = LINE_WORDS * dcache_pkg::STRB_BITS;

   typedef logic [LINE_BITS-1:0] line_t;

   //////////////////////////////
   // storage
   //////////////////////////////

   // contents only meaningful where the tag array says valid
   line_t mem [NUM_LINES];

   // write port
   // only bytes with byte_en set change
   // takes effect at the edge it is presented
   always_ff @(posedge clk) begin
      if (port.wr_en) begin
         for (int b = 0; b < LINE_BYTES; b++) begin
            if (port.byte_en[b]) begin
               mem[port.index][b*8 +: 8] <= port.wdata[b*8 +: 8];
            end
         end
      end
   end

   //////////////////////////////
   // read port
   //////////////////////////////

   // whole line, out on the cycle after rd_en
   // held until the next read
   always_ff @(posedge clk) begin
      if (port.rd_en) begin
         port.rdata <= mem[port.index];
      end
   end

endmodule

// ==== hdl/dcache_tag_array.sv ====
/* dcache tag array
   per-line tag storage with valid and dirty flags, registered read */
`timescale 1ns/1ps

module dcache_tag_array #(
   parameter int INDEX_BITS = 4,
   parameter int TAG_BITS   = 26
) (
   input logic       clk,
   input logic       rst,
   tag_port_if.array port
);

   localparam int NUM_LINES = 2 ** INDEX_BITS;

   typedef logic [TAG_BITS-1:0] tag_t;

   //////////////////////////////
   // state
   //////////////////////////////

   // tags themselves are plain storage
   tag_t tag_mem [NUM_LINES];

   // flags live in flops so reset empties the cache
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // tag write, same edge
   always_ff @(posedge clk) begin
      if (port.wr_en) begin
         tag_mem[port.index] <= port.wtag;
      end
   end

   // flag update
   // a write always validates, dirty loaded from set_dirty
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (port.wr_en) begin
         valid_q[port.index] <= 1'b1;
         dirty_q[port.index] <= port.set_dirty;
      end
   end

   //////////////////////////////
   // read port
   //////////////////////////////

   // one cycle after rd_en, held until the next read
   always_ff @(posedge clk) begin
      if (rst) begin
         port.rvalid <= 1'b0;
         port.rdirty <= 1'b0;
      end else if (port.rd_en) begin
         port.rvalid <= valid_q[port.index];
         port.rdirty <= dirty_q[port.index];
      end
   end

   always_ff @(posedge clk) begin
      if (port.rd_en) begin
         port.rtag <= tag_mem[port.index];
      end
   end

endmodule

// ==== hdl/dcache_ctrl.sv ====
/* dcache controller
   blocking hit/miss FSM, write-back and allocation sequencing, array steering */
`timescale 1ns/1ps

module dcache_ctrl #(
   parameter int LINE_WORDS = 4,
   parameter int INDEX_BITS = 4,
   parameter int TAG_BITS   = 26
) (
   input  logic                                       clk,
   input  logic                                       rst,
   // processor request
   input  dcache_pkg::addr_t                          req_addr,
   input  dcache_pkg::strb_t                          req_wstrb,
   input  dcache_pkg::word_t                          req_wdata,
   input  logic                                       req_valid,
   output logic                                       req_ready,
   // processor response
   output dcache_pkg::word_t                          resp_data,
   output logic                                       resp_valid,
   input  logic                                       resp_ready,
   // write-back request and completion
   output dcache_pkg::addr_t                          wb_addr,
   output logic [LINE_WORDS*dcache_pkg::WORD_BITS-1:0] wb_data,
   output logic                                       wb_valid,
   input  logic                                       wb_ready,
   input  logic                                       wb_done_valid,
   output logic                                       wb_done_ready,
   // allocation request and response
   output dcache_pkg::addr_t                          alloc_addr,
   output logic                                       alloc_valid,
   input  logic                                       alloc_ready,
   input  logic [LINE_WORDS*dcache_pkg::WORD_BITS-1:0] alloc_data,
   input  logic                                       alloc_data_valid,
   output logic                                       alloc_data_ready,
   // array ports
   data_port_if.ctrl                                  data,
   tag_port_if.ctrl                                   tag
);

   localparam int WORD_BITS  = dcache_pkg::WORD_BITS;
   localparam int STRB_BITS  = dcache_pkg::STRB_BITS;
   localparam int BOFF_BITS  = dcache_pkg::BYTE_OFF_BITS;
   localparam int WOFF_BITS  = $clog2(LINE_WORDS);
   localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;
   localparam int LINE_BYTES = LINE_WORDS * STRB_BITS;

   typedef logic [TAG_BITS-1:0]   tag_t;
   typedef logic [INDEX_BITS-1:0] index_t;
   typedef logic [WOFF_BITS-1:0]  woff_t;
   typedef logic [LINE_BITS-1:0]  line_t;
   typedef logic [LINE_BYTES-1:0] line_mask_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WB_REQ,
      WB_WAIT,
      ALLOC_REQ,
      ALLOC_WAIT,
      REFILL
   } state_t;

   state_t state;
   state_t state_next;

   //////////////////////////////
   // latched request
   //////////////////////////////

   dcache_pkg::addr_t req_addr_q;
   dcache_pkg::strb_t req_wstrb_q;
   dcache_pkg::word_t req_wdata_q;

   logic   req_fire;
   logic   is_write;
   tag_t   req_tag;
   index_t req_index;
   woff_t  req_woff;
   index_t in_index;

   assign req_fire = req_valid && req_ready;
   assign is_write = |req_wstrb_q;

   // address split of the held request
   assign req_tag   = req_addr_q[dcache_pkg::ADDR_BITS-1 -: TAG_BITS];
   assign req_index = req_addr_q[BOFF_BITS+WOFF_BITS +: INDEX_BITS];
   assign req_woff  = req_addr_q[BOFF_BITS +: WOFF_BITS];
   // index straight off the port, for the lookup read at accept
   assign in_index  = req_addr[BOFF_BITS+WOFF_BITS +: INDEX_BITS];

   always_ff @(posedge clk) begin
      if (req_fire) begin
         req_addr_q  <= req_addr;
         req_wstrb_q <= req_wstrb;
         req_wdata_q <= req_wdata;
      end
   end

   //////////////////////////////
   // lookup result
   //////////////////////////////

   logic              hit;
   logic              victim_dirty;
   logic              resp_set;
   logic              write_hit;
   logic              alloc_fire;
   dcache_pkg::word_t sel_word;
   line_mask_t        wr_mask;

   // array outputs are valid throughout LOOKUP
   assign hit          = tag.rvalid && (tag.rtag == req_tag);
   assign victim_dirty = tag.rvalid && tag.rdirty;
   assign sel_word     = data.rdata[req_woff*WORD_BITS +: WORD_BITS];

   // read hit registers the word, write hit merges into the array
   assign resp_set   = (state == LOOKUP) && !resp_valid && hit && !is_write;
   assign write_hit  = (state == LOOKUP) && hit && is_write;
   assign alloc_fire = (state == ALLOC_WAIT) && alloc_data_valid;

   // word strobe placed at the word offset
   always_comb begin
      for (int w = 0; w < LINE_WORDS; w++) begin
         wr_mask[w*STRB_BITS +: STRB_BITS] =
            (req_woff == woff_t'(w)) ? req_wstrb_q : '0;
      end
   end

   //////////////////////////////
   // state and response
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         resp_valid <= 1'b0;
      end else begin
         state <= state_next;
         if (resp_set) begin
            resp_valid <= 1'b1;
         end else if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
         end
      end
   end

   // held stable while resp_valid waits for ready
   always_ff @(posedge clk) begin
      if (resp_set) begin
         resp_data <= sel_word;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (req_fire) begin
               state_next = LOOKUP;
            end
         end
         LOOKUP: begin
            // pending read response, leave once taken
            if (resp_valid) begin
               if (resp_ready) begin
                  state_next = IDLE;
               end
            end else if (hit) begin
               if (is_write) begin
                  state_next = IDLE;
               end
            end else if (victim_dirty) begin
               state_next = WB_REQ;
            end else begin
               state_next = ALLOC_REQ;
            end
         end
         WB_REQ: begin
            if (wb_ready) begin
               state_next = WB_WAIT;
            end
         end
         WB_WAIT: begin
            if (wb_done_valid) begin
               state_next = ALLOC_REQ;
            end
         end
         ALLOC_REQ: begin
            if (alloc_ready) begin
               state_next = ALLOC_WAIT;
            end
         end
         ALLOC_WAIT: begin
            if (alloc_data_valid) begin
               state_next = REFILL;
            end
         end
         // second lookup of the same request, hits now
         REFILL: begin
            state_next = LOOKUP;
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   //////////////////////////////
   // channels
   //////////////////////////////

   assign req_ready        = (state == IDLE);
   assign wb_valid         = (state == WB_REQ);
   assign wb_done_ready    = (state == WB_WAIT);
   assign alloc_valid      = (state == ALLOC_REQ);
   assign alloc_data_ready = (state == ALLOC_WAIT);

   // victim line still sits in the array read registers
   assign wb_data    = data.rdata;
   assign wb_addr    = {tag.rtag, req_index, {(WOFF_BITS+BOFF_BITS){1'b0}}};
   assign alloc_addr = {req_tag, req_index, {(WOFF_BITS+BOFF_BITS){1'b0}}};

   //////////////////////////////
   // array steering
   //////////////////////////////

   // lookup read at accept uses the port address, later ones the held one
   assign data.index   = (state == IDLE) ? in_index : req_index;
   assign data.rd_en   = (state == IDLE && req_fire) || (state == REFILL);
   assign data.wr_en   = write_hit || alloc_fire;
   // refill fills every byte, a write hit only its strobed bytes
   assign data.byte_en = alloc_fire ? {LINE_BYTES{1'b1}} : wr_mask;
   assign data.wdata   = alloc_fire ? line_t'(alloc_data) : {LINE_WORDS{req_wdata_q}};

   assign tag.index     = data.index;
   assign tag.rd_en     = data.rd_en;
   assign tag.wr_en     = data.wr_en;
   assign tag.wtag      = req_tag;
   // clean after refill, dirty after a write hit
   assign tag.set_dirty = write_hit;

endmodule

// ==== hdl/dcache_top.sv ====
/* dcache top level
   direct-mapped write-back cache, arrays and controller wired together */
`timescale 1ns/1ps

module dcache_top #(
   parameter int LINE_WORDS = 4,
   parameter int INDEX_BITS = 4
) (
   input  logic                                       clk,
   input  logic                                       rst,
   // processor side
   input  dcache_pkg::addr_t                          req_addr,
   input  dcache_pkg::strb_t                          req_wstrb,
   input  dcache_pkg::word_t                          req_wdata,
   input  logic                                       req_valid,
   output logic                                       req_ready,
   output dcache_pkg::word_t                          resp_data,
   output logic                                       resp_valid,
   input  logic                                       resp_ready,
   // write-back channel
   output dcache_pkg::addr_t                          wb_addr,
   output logic [LINE_WORDS*dcache_pkg::WORD_BITS-1:0] wb_data,
   output logic                                       wb_valid,
   input  logic                                       wb_ready,
   input  logic                                       wb_done_valid,
   output logic                                       wb_done_ready,
   // allocation channel
   output dcache_pkg::addr_t                          alloc_addr,
   output logic                                       alloc_valid,
   input  logic                                       alloc_ready,
   input  logic [LINE_WORDS*dcache_pkg::WORD_BITS-1:0] alloc_data,
   input  logic                                       alloc_data_valid,
   output logic                                       alloc_data_ready
);

   // what is left of the address above index and offsets
   localparam int TAG_BITS = dcache_pkg::ADDR_BITS - INDEX_BITS
                             - $clog2(LINE_WORDS) - dcache_pkg::BYTE_OFF_BITS;

   data_port_if #(.LINE_WORDS(LINE_WORDS), .INDEX_BITS(INDEX_BITS)) data_if ();
   tag_port_if  #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS))     tag_if ();

   // both arrays see the same index each cycle
   dcache_data_array #(.LINE_WORDS(LINE_WORDS), .INDEX_BITS(INDEX_BITS)) u_data_array (
      .clk  (clk),
      .port (data_if)
   );

   dcache_tag_array #(.INDEX_BITS(INDEX_BITS), .TAG_BITS(TAG_BITS)) u_tag_array (
      .clk  (clk),
      .rst  (rst),
      .port (tag_if)
   );

   dcache_ctrl #(
      .LINE_WORDS (LINE_WORDS),
      .INDEX_BITS (INDEX_BITS),
      .TAG_BITS   (TAG_BITS)
   ) u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .req_addr         (req_addr),
      .req_wstrb        (req_wstrb),
      .req_wdata        (req_wdata),
      .req_valid        (req_valid),
      .req_ready        (req_ready),
      .resp_data        (resp_data),
      .resp_valid       (resp_valid),
      .resp_ready       (resp_ready),
      .wb_addr          (wb_addr),
      .wb_data          (wb_data),
      .wb_valid         (wb_valid),
      .wb_ready         (wb_ready),
      .wb_done_valid    (wb_done_valid),
      .wb_done_ready    (wb_done_ready),
      .alloc_addr       (alloc_addr),
      .alloc_valid      (alloc_valid),
      .alloc_ready      (alloc_ready),
      .alloc_data       (alloc_data),
      .alloc_data_valid (alloc_data_valid),
      .alloc_data_ready (alloc_data_ready),
      .data             (data_if),
      .tag              (tag_if)
   );

endmodule

// ==== sim/dcache_assert.sv ====
/* dcache protocol assertions
   channel exclusion and handshake stability on the controller ports */
`timescale 1ns/1ps

module dcache_assert (
   input logic              clk,
   input logic              rst,
   input logic              req_ready,
   input dcache_pkg::word_t resp_data,
   input logic              resp_valid,
   input logic              resp_ready,
   input dcache_pkg::addr_t wb_addr,
   input logic              wb_valid,
   input logic              wb_ready,
   input logic              alloc_valid
);

   // read back by the testbench at the end
   int fail_count = 0;

   // one memory channel request at a time
   a_one_channel: assert property (@(posedge clk) disable iff (rst)
      !(wb_valid && alloc_valid))
      else begin
         $error("wb_valid and alloc_valid high together");
         fail_count++;
      end

   // write-back request held with its address until taken
   a_wb_hold: assert property (@(posedge clk) disable iff (rst)
      (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_addr)))
      else begin
         $error("wb_valid dropped or wb_addr changed before wb_ready");
         fail_count++;
      end

   // response held with its data until taken
   a_resp_hold: assert property (@(posedge clk) disable iff (rst)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data)))
      else begin
         $error("resp_valid dropped or resp_data changed before resp_ready");
         fail_count++;
      end

   // blocking cache, no new request while a response waits
   a_no_accept: assert property (@(posedge clk) disable iff (rst)
      resp_valid |-> !req_ready)
      else begin
         $error("req_ready high while a response is pending");
         fail_count++;
      end

endmodule

bind dcache_ctrl dcache_assert u_assert (
   .clk         (clk),
   .rst         (rst),
   .req_ready   (req_ready),
   .resp_data   (resp_data),
   .resp_valid  (resp_valid),
   .resp_ready  (resp_ready),
   .wb_addr     (wb_addr),
   .wb_valid    (wb_valid),
   .wb_ready    (wb_ready),
   .alloc_valid (alloc_valid)
);

// ==== sim/dcache_tb.sv ====
/* dcache testbench
   seeded random loads and stores against a flat memory model and a line memory responder */
`timescale 1ns/1ps

module dcache_tb;

   localparam int LINE_WORDS     = 4;
   localparam int LINE_BITS      = LINE_WORDS * dcache_pkg::WORD_BITS;
   localparam int NUM_LINES      = 64;
   localparam int NUM_WORDS      = NUM_LINES * LINE_WORDS;
   localparam int CACHE_LINES    = 16;
   localparam int NUM_RANDOM     = 400;
   localparam int NUM_REQS       = CACHE_LINES + 5 + NUM_RANDOM;
   localparam int TIMEOUT_CYCLES = NUM_REQS * 40 + 1000;
   // upper tag bits set so the whole tag gets exercised
   localparam dcache_pkg::addr_t BASE_ADDR = 32'h4000_0000;

   typedef logic [LINE_BITS-1:0] line_t;

   logic              clk;
   logic              rst;
   dcache_pkg::addr_t req_addr;
   dcache_pkg::strb_t req_wstrb;
   dcache_pkg::word_t req_wdata;
   logic              req_valid;
   logic              req_ready;
   dcache_pkg::word_t resp_data;
   logic              resp_valid;
   logic              resp_ready;
   dcache_pkg::addr_t wb_addr;
   line_t             wb_data;
   logic              wb_valid;
   logic              wb_ready;
   logic              wb_done_valid;
   logic              wb_done_ready;
   dcache_pkg::addr_t alloc_addr;
   logic              alloc_valid;
   logic              alloc_ready;
   line_t             alloc_data;
   logic              alloc_data_valid;
   logic              alloc_data_ready;

   //////////////////////////////
   // models and bookkeeping
   //////////////////////////////

   // flat word memory with every accepted write applied
   dcache_pkg::word_t model_mem [NUM_WORDS];
   // what the memory side really holds
   dcache_pkg::word_t back_mem [NUM_WORDS];
   // per index: valid, dirty, which line
   bit mvalid [CACHE_LINES];
   bit mdirty [CACHE_LINES];
   int mline  [CACHE_LINES];

   // expectations for the memory side, set before each request
   bit                exp_wb;
   dcache_pkg::addr_t exp_wb_addr;
   line_t             exp_wb_data;
   dcache_pkg::addr_t exp_alloc_addr;
   // write-back count when the request went out
   int                wb_start;

   int cyc = 0;
   int errors = 0;
   int tests = 0;
   int requests = 0;
   int reads = 0;
   int resp_count = 0;
   int wb_count = 0;
   int alloc_count = 0;

   dcache_top u_dcache_top (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // every response handshake, duplicates included
   always @(posedge clk) begin
      if (!rst && resp_valid && resp_ready) begin
         resp_count <= resp_count + 1;
      end
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   function automatic dcache_pkg::word_t fill_word(input int i);
      return (dcache_pkg::word_t'(i) * 32'h0101_0101) ^ 32'hc35a_0000;
   endfunction

   function automatic dcache_pkg::addr_t line_addr(input int ln);
      return BASE_ADDR | dcache_pkg::addr_t'(ln * 16);
   endfunction

   function automatic line_t model_line(input int ln);
      line_t l;
      for (int w = 0; w < LINE_WORDS; w++) begin
         l[w*32 +: 32] = model_mem[ln*LINE_WORDS + w];
      end
      return l;
   endfunction

   function automatic line_t back_line(input int ln);
      line_t l;
      for (int w = 0; w < LINE_WORDS; w++) begin
         l[w*32 +: 32] = back_mem[ln*LINE_WORDS + w];
      end
      return l;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic flag_mismatch(input string sig, input line_t expected, input line_t actual);
      $display("Error: %s expected %0h got %0h", sig, expected, actual);
      errors++;
   endtask

   task automatic flag_problem(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic end_test(input string name, input int err0);
      $display("test %s: %0d errors", name, errors - err0);
      tests++;
   endtask

   task automatic check_reset_state();
      if (req_ready !== 1'b1) flag_mismatch("req_ready", line_t'(1'b1), line_t'(req_ready));
      if (resp_valid !== 1'b0) flag_mismatch("resp_valid", '0, line_t'(resp_valid));
      if (wb_valid !== 1'b0) flag_mismatch("wb_valid", '0, line_t'(wb_valid));
      if (alloc_valid !== 1'b0) flag_mismatch("alloc_valid", '0, line_t'(alloc_valid));
      if (wb_done_ready !== 1'b0) flag_mismatch("wb_done_ready", '0, line_t'(wb_done_ready));
      if (alloc_data_ready !== 1'b0) begin
         flag_mismatch("alloc_data_ready", '0, line_t'(alloc_data_ready));
      end
   endtask

   // one request start to finish, predicted from the model cache
   task automatic run_request(input dcache_pkg::addr_t addr, input dcache_pkg::strb_t strb,
                              input dcache_pkg::word_t wdata);
      int                ln;
      int                idx;
      int                wi;
      int                al0;
      int                acc_cyc;
      int                seen_cyc;
      bit                hit;
      bit                is_wr;
      bit                done;
      dcache_pkg::word_t got;
      ln    = int'(addr[9:4]);
      idx   = ln % CACHE_LINES;
      wi    = int'(addr[9:2]);
      is_wr = (strb != '0);
      hit   = mvalid[idx] && (mline[idx] == ln);
      exp_wb         = !hit && mvalid[idx] && mdirty[idx];
      exp_wb_addr    = line_addr(mline[idx]);
      exp_wb_data    = model_line(mline[idx]);
      exp_alloc_addr = {addr[31:4], 4'h0};
      wb_start = wb_count;
      al0 = alloc_count;
      req_addr  <= addr;
      req_wstrb <= strb;
      req_wdata <= wdata;
      req_valid <= 1'b1;
      @(posedge clk);
      while (!req_ready) @(posedge clk);
      acc_cyc = cyc;
      req_valid <= 1'b0;
      requests++;
      if (is_wr) begin
         // write done once req_ready is back
         @(posedge clk);
         while (!req_ready) @(posedge clk);
         if (hit && (cyc - acc_cyc != 2)) begin
            flag_problem($sformatf("write hit at %h took %0d cycles, not 2", addr, cyc - acc_cyc));
         end
         for (int b = 0; b < dcache_pkg::STRB_BITS; b++) begin
            if (strb[b]) model_mem[wi][b*8 +: 8] = wdata[b*8 +: 8];
         end
      end else begin
         reads++;
         seen_cyc = -1;
         done = 1'b0;
         got = '0;
         while (!done) begin
            @(posedge clk);
            if (resp_valid && seen_cyc < 0) seen_cyc = cyc;
            if (resp_valid && resp_ready) begin
               done = 1'b1;
               got = resp_data;
            end
         end
         if (got !== model_mem[wi]) begin
            flag_mismatch("resp_data", line_t'(model_mem[wi]), line_t'(got));
         end
         if (hit && (seen_cyc - acc_cyc != 2)) begin
            flag_problem($sformatf("read hit at %h: resp_valid after %0d cycles, not 2",
                                   addr, seen_cyc - acc_cyc));
         end
      end
      if (wb_count - wb_start != int'(exp_wb)) begin
         flag_problem($sformatf("request at %h: %0d write-backs, %0d expected",
                                addr, wb_count - wb_start, int'(exp_wb)));
      end
      if (alloc_count - al0 != int'(!hit)) begin
         flag_problem($sformatf("request at %h: %0d allocations, %0d expected",
                                addr, alloc_count - al0, int'(!hit)));
      end
      // index now holds the requested line
      mdirty[idx] = (hit && mdirty[idx]) || is_wr;
      mvalid[idx] = 1'b1;
      mline[idx]  = ln;
   endtask

   //////////////////////////////
   // memory side
   //////////////////////////////

   initial begin : wb_side
      dcache_pkg::addr_t got_addr;
      line_t             got_data;
      wb_ready      <= 1'b0;
      wb_done_valid <= 1'b0;
      forever begin
         @(posedge clk);
         if (!rst && wb_valid) begin
            wait_cycles($urandom_range(3, 0));
            wb_ready <= 1'b1;
            @(posedge clk);
            wb_ready <= 1'b0;
            got_addr = wb_addr;
            got_data = wb_data;
            wb_count++;
            if (got_addr !== exp_wb_addr) flag_mismatch("wb_addr", line_t'(exp_wb_addr),
                                                         line_t'(got_addr));
            if (got_data !== exp_wb_data) flag_mismatch("wb_data", exp_wb_data, got_data);
            for (int w = 0; w < LINE_WORDS; w++) begin
               back_mem[int'(got_addr[9:4])*LINE_WORDS + w] = got_data[w*32 +: 32];
            end
            // completion after its own delay
            wait_cycles($urandom_range(3, 0));
            wb_done_valid <= 1'b1;
            @(posedge clk);
            while (!wb_done_ready) @(posedge clk);
            wb_done_valid <= 1'b0;
         end
      end
   end

   initial begin : alloc_side
      dcache_pkg::addr_t got_addr;
      alloc_ready      <= 1'b0;
      alloc_data       <= '0;
      alloc_data_valid <= 1'b0;
      forever begin
         @(posedge clk);
         if (!rst && alloc_valid) begin
            wait_cycles($urandom_range(3, 0));
            alloc_ready <= 1'b1;
            @(posedge clk);
            alloc_ready <= 1'b0;
            got_addr = alloc_addr;
            alloc_count++;
            if (got_addr !== exp_alloc_addr) flag_mismatch("alloc_addr", line_t'(exp_alloc_addr),
                                                           line_t'(got_addr));
            // a dirty victim goes out before its replacement comes in
            if (exp_wb && wb_count == wb_start) begin
               flag_problem($sformatf("allocation at %h before the write-back", got_addr));
            end
            wait_cycles($urandom_range(3, 0));
            alloc_data       <= back_line(int'(got_addr[9:4]));
            alloc_data_valid <= 1'b1;
            @(posedge clk);
            while (!alloc_data_ready) @(posedge clk);
            alloc_data_valid <= 1'b0;
         end
      end
   end

   // response stalls, ready three times in four
   initial begin : resp_stall
      resp_ready <= 1'b0;
      forever begin
         @(posedge clk);
         resp_ready <= ($urandom_range(3, 0) != 0);
      end
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
   end

   //////////////////////////////
   // test sequence
   //////////////////////////////

   initial begin : main
      int                err0;
      int                ln;
      int                woff;
      dcache_pkg::strb_t strb;
      void'($urandom(78));
      rst       <= 1'b1;
      req_addr  <= '0;
      req_wstrb <= '0;
      req_wdata <= '0;
      req_valid <= 1'b0;
      for (int i = 0; i < NUM_WORDS; i++) begin
         model_mem[i] = fill_word(i);
         back_mem[i]  = fill_word(i);
      end
      for (int i = 0; i < CACHE_LINES; i++) begin
         mvalid[i] = 1'b0;
         mdirty[i] = 1'b0;
         mline[i]  = 0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      err0 = errors;
      check_reset_state();
      end_test("reset_state", err0);

      // first touch of every index, clean allocations only
      err0 = errors;
      for (int i = 0; i < CACHE_LINES; i++) begin
         run_request(line_addr(i) | 32'(($urandom_range(3, 0)) * 4), '0, '0);
      end
      end_test("cold_fill", err0);

      // dirty victim, clean victim, hit, then refetch of the written line
      err0 = errors;
      run_request(line_addr(5) | 32'h4, 4'hf, 32'hdead_beef);
      run_request(line_addr(21) | 32'h4, '0, '0);
      run_request(line_addr(37) | 32'h8, '0, '0);
      run_request(line_addr(37) | 32'hc, '0, '0);
      run_request(line_addr(5) | 32'h4, '0, '0);
      end_test("eviction", err0);

      err0 = errors;
      for (int n = 0; n < NUM_RANDOM; n++) begin
         ln   = $urandom_range(NUM_LINES - 1, 0);
         woff = $urandom_range(LINE_WORDS - 1, 0);
         if ($urandom_range(1, 0) == 0) begin
            strb = '0;
         end else begin
            strb = dcache_pkg::strb_t'($urandom_range(15, 1));
         end
         run_request(line_addr(ln) | 32'(woff * 4), strb, $urandom());
      end
      end_test("random_mix", err0);

      repeat (2) @(posedge clk);
      if (resp_count != reads) begin
         flag_problem($sformatf("%0d responses for %0d accepted reads", resp_count, reads));
      end
      if (u_dcache_top.u_ctrl.u_assert.fail_count != 0) begin
         flag_problem("protocol assertions failed during the run");
      end
      $display("tests %0d, requests %0d, reads %0d, responses %0d, errors %0d",
               tests, requests, reads, resp_count, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/dcache_ifs.sv
hdl/dcache_data_array.sv
hdl/dcache_tag_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/dcache_assert.sv
sim/dcache_tb.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the dcache project

TOOL     = verilator
TOP      = dcache_tb
FILELIST = dcache.f
FLAGS    = --binary --timing --assert -j 0
LINT     = --lint-only --timing
OBJDIR   = obj_dir
LOG      = sim.log
FAIL_MSG = sim failed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
